// File: verilog.f
+incdir+.
cd_bus_pkg.sv
cd_dma_pkg.sv
cd_regs.sv
cd_irq.sv
cd_dma.sv
cd_sys.sv
tb_cd_sys.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_cd_sys -f verilog.f \
	-o tb_cd_sys > build.log 2>&1 \
	&& ./obj_dir/tb_cd_sys 2>&1 | tee sim.log \
	|| { echo "build or run error, see build.log"; exit 1; }
grep -q "test failed" sim.log && exit 1
grep -q "test passed" sim.log || exit 1
exit 0

// File: tb_cd_checks.svh
// Testbench compare tasks and random source
`ifndef TB_CD_CHECKS_SVH
`define TB_CD_CHECKS_SVH

int errors = 0;
int checks = 0;
logic [31:0] lcg_state = 32'd90;	// Seed

// LCG, one bit per call
function automatic logic lcg_bit();
	lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
	return lcg_state[16];
endfunction

task automatic check_word(input string name, input word_t got, input word_t exp);
	checks++;
	if (got !== exp)
	begin
		errors++;
		$display("Fail %s got %h exp %h", name, got, exp);
	end
endtask

task automatic check_ctrl(input cd_ctrl_t got, input cd_ctrl_t exp);
	checks++;
	if (got !== exp)
	begin
		errors++;
		$display("Fail ctrl got %h exp %h", got, exp);
	end
endtask

task automatic check_tr(input tr_wr_t got, input tr_wr_t exp);
	checks++;
	if (got !== exp)
	begin
		errors++;
		$display("Fail tr got %h exp %h", got, exp);
	end
endtask

task automatic check_mem(input int idx, input dma_addr_t got_a, input word_t got_d,
	input dma_addr_t exp_a, input word_t exp_d);
	checks++;
	if ((got_a !== exp_a) || (got_d !== exp_d))
	begin
		errors++;
		$display("Fail mem[%0d] got %h:%h exp %h:%h", idx, got_a, got_d, exp_a, exp_d);
	end
endtask

// Failures that are not a wrong value
task automatic fail_plain(input string msg);
	errors++;
	$display("%s", msg);
endtask

`endif

// File: tb_cd_sys.sv
// CD system block testbench
`timescale 1ns/100ps

module tb_cd_sys;
	import cd_bus_pkg::*;
	import cd_dma_pkg::*;
	`include "tb_cd_checks.svh"

	typedef enum {K_CTRL, K_WR, K_ZONE, K_IACK, K_TOP, K_CDC, K_CDD, K_IRQ, K_RUN, K_IDLE} kind_t;
	typedef struct {
		kind_t kind;
		logic [23:0] addr;	// Byte address
		word_t data;
		word_t exp;
		int budget;			// Cycles
		string name;
	} row_t;
	typedef struct {
		dma_addr_t addr;
		word_t data;
		logic gack;			// nbgack seen at the write
	} mem_wr_t;

	logic CLK_68KCLK = 1'b0;
	logic nRESET;
	cpu_bus_t cpu;
	logic [1:0] system_type, cd_region;
	logic cd_lid, cdd_nirq, cdc_nirq, nbg, dma_sdram_busy;
	word_t dma_data_in, rd_data;
	logic rd_en, cd_irq, nbr, nbgack, dma_running;
	cd_ctrl_t ctrl;
	tr_wr_t tr;
	dma_mem_t dma_mem;

	row_t rows[$];
	mem_wr_t mem_q[$];
	longint watch_ns = 0;
	logic busy_en = 1'b0;
	logic wr_seen = 1'b0;
	int gnt_wait = 0;
	// Reference model state
	cd_ctrl_t exp_ctrl;
	tr_area_t exp_area;
	dma_addr_t cfg_a, cfg_b;
	word_t cfg_v;
	dma_count_t cfg_n;

	cd_sys dut0(.*);

	always #50 CLK_68KCLK = ~CLK_68KCLK;

	function automatic word_t mem_pattern(input dma_addr_t a);
		return a[15:0] ^ {a[7:0], a[23:16]};	// Uses every address bit
	endfunction

	// ======================================================================
	// Bus, grant and memory models
	// ======================================================================

	always @(posedge CLK_68KCLK)
	begin
		#10;
		dma_sdram_busy = busy_en ? lcg_bit() : 1'b0;
		// Read data only while rd is up
		dma_data_in = dma_mem.rd ? mem_pattern(dma_mem.addr_in) : 16'h0000;
		if (nbr)
		begin
			gnt_wait = 0;
			nbg = 1'b1;
		end
		else
		begin
			gnt_wait++;
			if (gnt_wait >= 3)
				nbg = 1'b0;		// Grant a few cycles late
		end
	end

	// One entry per wr pulse
	always @(negedge CLK_68KCLK)
	begin
		if (dma_mem.wr && !wr_seen)
			mem_q.push_back('{dma_mem.addr_out, dma_mem.data_out, nbgack});
		wr_seen = dma_mem.wr;
	end

	task automatic add_row(input kind_t k, input logic [23:0] a, input word_t d,
		input word_t e, input int b, input string n);
		rows.push_back('{k, a, d, e, b, n});
	endtask

	task automatic bus_write(input logic [23:0] a, input word_t d);
		@(posedge CLK_68KCLK);
		#10;
		cpu.addr = a[23:1];
		cpu.data = d;
		cpu.rw = 1'b0;
		cpu.nas = 1'b0;
		cpu.nlds = 1'b0;
		cpu.nuds = 1'b0;
		repeat (2) @(posedge CLK_68KCLK);
		#10;
	endtask

	task automatic bus_release();
		cpu.rw = 1'b1;
		cpu.nas = 1'b1;
		cpu.nlds = 1'b1;
		cpu.nuds = 1'b1;
		cpu.iack = 1'b0;
	endtask

	task automatic bus_read(input logic [23:0] a, input logic ia, output word_t d);
		@(posedge CLK_68KCLK);
		#10;
		cpu.addr = a[23:1];
		cpu.rw = 1'b1;
		cpu.nas = 1'b0;
		cpu.iack = ia;
		@(posedge CLK_68KCLK);
		#10;
		d = rd_data;
		check_word("rd_en", {15'd0, rd_en}, 16'd1);
		bus_release();
	endtask

	// Register meanings for the expected values
	task automatic model_write(input logic [23:0] a, input word_t d);
		case (a)
			{CD_WINDOW_HI, REG_DISBLSPR}: exp_ctrl.spr_en = ~d[0];
			{CD_WINDOW_HI, REG_DISBLFIX}: exp_ctrl.fix_en = ~d[0];
			{CD_WINDOW_HI, REG_ENVIDEO}: exp_ctrl.video_en = d[0];
			{CD_WINDOW_HI, REG_Z80_RESET}: exp_ctrl.nreset_z80 = d[0];
			{CD_WINDOW_HI, REG_SPRBANK}: exp_ctrl.spr_bank = d[1:0];
			{CD_WINDOW_HI, REG_PCMBANK}: exp_ctrl.pcm_bank = d[0];
			{CD_WINDOW_HI, REG_TR_AREA}: exp_area = d[2:0];
			{CD_WINDOW_HI, REG_DMA_ADDR_A_HI}: cfg_a[23:16] = d[7:0];
			{CD_WINDOW_HI, REG_DMA_ADDR_A_LO}: cfg_a[15:0] = d;
			{CD_WINDOW_HI, REG_DMA_ADDR_B_HI}: cfg_b[23:16] = d[7:0];
			{CD_WINDOW_HI, REG_DMA_ADDR_B_LO}: cfg_b[15:0] = d;
			{CD_WINDOW_HI, REG_DMA_VALUE_HI}: cfg_v = d;
			{CD_WINDOW_HI, REG_DMA_COUNT_HI}: cfg_n[31:16] = d;
			{CD_WINDOW_HI, REG_DMA_COUNT_LO}: cfg_n[15:0] = d;
			default: ;
		endcase
	endtask

	task automatic pulse_irq(input logic cdc, input word_t e);
		@(posedge CLK_68KCLK);
		#10;
		if (cdc)
			cdc_nirq = 1'b0;
		else
			cdd_nirq = 1'b0;
		repeat (2) @(posedge CLK_68KCLK);
		#10;
		cdc_nirq = 1'b1;
		cdd_nirq = 1'b1;
		repeat (6) @(posedge CLK_68KCLK);	// Sync plus flag plus output register
		#10;
		check_word("cd_irq", {15'd0, cd_irq}, e);
	endtask

	// Waits out one DMA job, then checks the write log
	task automatic run_dma(input logic fill, input logic stall, input int budget);
		int n;
		dma_addr_t ea;
		word_t ed;
		n = 0;
		busy_en = stall;
		while ((dma_running === 1'b1) && (n < budget))
		begin
			@(posedge CLK_68KCLK);
			#10;
			n++;
		end
		busy_en = 1'b0;
		if (n >= budget)
			fail_plain("DMA job did not finish within its cycle budget");
		check_word("nbr", {15'd0, nbr}, 16'd1);
		check_word("nbgack", {15'd0, nbgack}, 16'd1);
		check_word("mem_writes", 16'(mem_q.size()), cfg_n[15:0]);
		foreach (mem_q[k])
		begin
			ea = (fill ? cfg_a : cfg_b) + 24'(2 * k);
			ed = fill ? cfg_v : mem_pattern(cfg_a + 24'(2 * k));
			check_mem(k, mem_q[k].addr, mem_q[k].data, ea, ed);
			check_word("nbgack_at_wr", {15'd0, mem_q[k].gack}, 16'd0);
		end
	endtask

	// ======================================================================
	// Stimulus table
	// ======================================================================

	task automatic build_table();
		add_row(K_CTRL, 24'h0, 16'h0, 16'h0, 6, "ctrl after reset");
		add_row(K_WR, 24'hFF0111, 16'h0001, 16'h0, 5, "disable sprites");
		add_row(K_WR, 24'hFF0115, 16'h0000, 16'h0, 5, "enable fix");
		add_row(K_WR, 24'hFF0119, 16'h0000, 16'h0, 5, "video off");
		add_row(K_WR, 24'hFF0183, 16'h0001, 16'h0, 5, "release Z80");
		add_row(K_WR, 24'hFF01A1, 16'h0002, 16'h0, 5, "sprite bank 2");
		add_row(K_WR, 24'hFF01A3, 16'h0001, 16'h0, 5, "PCM bank 1");
		add_row(K_WR, 24'hFF016F, 16'h0001, 16'h0, 5, "upload enable");
		add_row(K_WR, 24'hFF0105, 16'h0004, 16'h0, 5, "area Z80");
		add_row(K_WR, 24'hFF0127, 16'h0000, 16'h0, 5, "map Z80");
		add_row(K_ZONE, 24'hE12344, 16'hABCD, 16'h2, 5, "zone write Z80");
		add_row(K_WR, 24'hFF0105, 16'h0001, 16'h0, 5, "area PCM");
		add_row(K_ZONE, 24'hE00010, 16'h1357, 16'h0, 5, "zone write PCM unmapped");
		add_row(K_WR, 24'hFF0105, 16'h0004, 16'h0, 5, "area Z80 again");
		add_row(K_WR, 24'hFF0147, 16'h0000, 16'h0, 5, "unmap Z80");
		add_row(K_ZONE, 24'hE0FFFE, 16'h2468, 16'h0, 5, "zone write Z80 unmapped");
		add_row(K_CDC, 24'h0, 16'h0, 16'h0, 12, "CDC pulse");
		add_row(K_IACK, 24'hFFFFF8, 16'h0, 16'd21, 4, "vector CDC");
		add_row(K_WR, 24'hFF0002, 16'h0010, 16'h0, 5, "comm enable");
		add_row(K_CDD, 24'h0, 16'h0, 16'h0, 12, "comm pulse");
		add_row(K_IACK, 24'hFFFFF8, 16'h0, 16'd22, 4, "vector comm");
		add_row(K_WR, 24'hFF000E, 16'h0030, 16'h0, 5, "ack both flags");
		add_row(K_IRQ, 24'h0, 16'h0, 16'h1, 6, "irq released");
		add_row(K_WR, 24'hFF0064, 16'h0020, 16'h0, 5, "fill addr A hi");
		add_row(K_WR, 24'hFF0066, 16'h1000, 16'h0, 5, "fill addr A lo");
		add_row(K_WR, 24'hFF006C, 16'h5A5A, 16'h0, 5, "fill value");
		add_row(K_WR, 24'hFF0070, 16'h0000, 16'h0, 5, "count hi");
		add_row(K_WR, 24'hFF0072, 16'h0004, 16'h0, 5, "count lo 4");
		add_row(K_WR, 24'hFF007E, UCODE_WORD_FILL, 16'h0, 5, "ucode fill");
		add_row(K_WR, 24'hFF0061, 16'h0040, 16'h0, 5, "start fill");
		add_row(K_RUN, 24'h0, 16'h1, 16'h0, 400, "word fill");
		add_row(K_WR, 24'hFF0064, 16'h0030, 16'h0, 5, "copy addr A hi");
		add_row(K_WR, 24'hFF0066, 16'h4000, 16'h0, 5, "copy addr A lo");
		add_row(K_WR, 24'hFF0068, 16'h0010, 16'h0, 5, "copy addr B hi");
		add_row(K_WR, 24'hFF006A, 16'h0800, 16'h0, 5, "copy addr B lo");
		add_row(K_WR, 24'hFF0072, 16'h0003, 16'h0, 5, "count lo 3");
		add_row(K_WR, 24'hFF007E, UCODE_WORD_COPY, 16'h0, 5, "ucode copy");
		add_row(K_WR, 24'hFF0061, 16'h0040, 16'h0, 5, "start copy");
		add_row(K_RUN, 24'h0, 16'h0, 16'h1, 900, "word copy with stalls");
		add_row(K_TOP, 24'hFF011C, 16'h0, 16'hDE00, 4, "top mech read");
		add_row(K_WR, 24'hFF007E, 16'h1234, 16'h0, 5, "unknown ucode");
		add_row(K_WR, 24'hFF0061, 16'h0040, 16'h0, 5, "start unknown");
		add_row(K_IDLE, 24'h0, 16'h0, 16'h0, 12, "no DMA for unknown ucode");
	endtask

	// Watchdog sized from the table
	initial
	begin
		wait (watch_ns > 0);
		#(watch_ns);
		$display("Watchdog expired before the table finished");
		$display("test failed");
		$finish;
	end

	initial
	begin
		word_t d;
		tr_wr_t exp_tr;
		logic seen;
		int e0;
		cpu = '{addr: '0, data: '0, rw: 1'b1, nas: 1'b1, nlds: 1'b1, nuds: 1'b1,
			iack: 1'b0, ndtack: 1'b1};
		nRESET = 1'b0;
		system_type = 2'b10;	// CD system
		cd_region = 2'b10;
		cd_lid = 1'b1;
		cdd_nirq = 1'b1;
		cdc_nirq = 1'b1;
		nbg = 1'b1;
		dma_data_in = '0;
		dma_sdram_busy = 1'b0;
		exp_ctrl = '{video_en: 1'b1, fix_en: 1'b1, spr_en: 1'b1, nreset_z80: 1'b0,
			spr_bank: 2'd0, pcm_bank: 1'b0};
		exp_area = AREA_SPR;
		cfg_a = '0;
		cfg_b = '0;
		cfg_v = '0;
		cfg_n = '0;
		build_table();
		foreach (rows[i])
			watch_ns += 100 * rows[i].budget;
		repeat (2) @(posedge CLK_68KCLK);
		#10;
		nRESET = 1'b1;

		foreach (rows[i])
		begin
			e0 = errors;
			case (rows[i].kind)
				K_CTRL: check_ctrl(ctrl, exp_ctrl);
				K_WR:
				begin
					bus_write(rows[i].addr, rows[i].data);
					bus_release();
					model_write(rows[i].addr, rows[i].data);
					check_ctrl(ctrl, exp_ctrl);
				end
				K_ZONE:
				begin
					bus_write(rows[i].addr, rows[i].data);	// Strobes still low here
					exp_tr = '{wr_spr: rows[i].exp[3], wr_pcm: rows[i].exp[2],
						wr_z80: rows[i].exp[1], wr_fix: rows[i].exp[0], area: exp_area,
						data: rows[i].data, addr: rows[i].addr[19:1]};
					check_tr(tr, exp_tr);
					bus_release();
				end
				K_IACK, K_TOP:
				begin
					bus_read(rows[i].addr, rows[i].kind == K_IACK, d);
					check_word("rd_data", d, rows[i].exp);
				end
				K_CDC: pulse_irq(1'b1, rows[i].exp);
				K_CDD: pulse_irq(1'b0, rows[i].exp);
				K_IRQ:
				begin
					repeat (4) @(posedge CLK_68KCLK);
					#10;
					check_word("cd_irq", {15'd0, cd_irq}, rows[i].exp);
				end
				K_RUN:
				begin
					mem_q.delete();		// Writes start well after the grant
					run_dma(rows[i].data[0], rows[i].exp[0], rows[i].budget - 10);
				end
				K_IDLE:
				begin
					seen = 1'b0;
					repeat (10)
					begin
						@(posedge CLK_68KCLK);
						#10;
						seen |= dma_running;
					end
					check_word("dma_running", {15'd0, seen}, 16'd0);
				end
				default: fail_plain("Unknown row kind in the table");
			endcase
			$display("%0d %s %s", i, rows[i].name, (errors == e0) ? "ok" : "FAIL");
		end

		$display("%0d rows, %0d checks, %0d errors", rows.size(), checks, errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

// File: cd_sys.sv
// CD system 68k-side control block
`timescale 1ns/100ps

module cd_sys(
	input logic CLK_68KCLK,
	input logic nRESET,
	input cd_bus_pkg::cpu_bus_t cpu,
	input logic [1:0] system_type,
	input logic [1:0] cd_region,
	input logic cd_lid,
	input logic cdd_nirq,
	input logic cdc_nirq,
	input logic nbg,
	input cd_bus_pkg::word_t dma_data_in,
	input logic dma_sdram_busy,
	output cd_bus_pkg::word_t rd_data,
	output logic rd_en,			// Outside drives the data bus when high
	output cd_bus_pkg::cd_ctrl_t ctrl,
	output cd_bus_pkg::tr_wr_t tr,
	output logic cd_irq,
	output logic nbr,
	output logic nbgack,
	output logic dma_running,
	output cd_dma_pkg::dma_mem_t dma_mem
);
	import cd_bus_pkg::*;
	import cd_dma_pkg::*;

	dma_cfg_t dma_cfg;
	dma_mode_t dma_mode;
	logic dma_start;			// One cycle
	irq_ctl_t irq_ctl;
	logic [7:0] irq_vector;

	cd_regs regs0(
		.CLK_68KCLK(CLK_68KCLK),
		.nRESET(nRESET),
		.cpu(cpu),
		.system_type(system_type),
		.cd_region(cd_region),
		.cd_lid(cd_lid),
		.irq_vector(irq_vector),
		.dma_running(dma_running),
		.dma_mem(dma_mem),
		.ctrl(ctrl),
		.tr(tr),
		.dma_cfg(dma_cfg),
		.dma_mode(dma_mode),
		.dma_start(dma_start),
		.irq_ctl(irq_ctl),
		.rd_data(rd_data),
		.rd_en(rd_en)
	);

	cd_irq irq0(
		.CLK_68KCLK(CLK_68KCLK),
		.nRESET(nRESET),
		.cdd_nirq(cdd_nirq),
		.cdc_nirq(cdc_nirq),
		.irq_ctl(irq_ctl),
		.cd_irq(cd_irq),
		.irq_vector(irq_vector)
	);

	cd_dma dma0(
		.CLK_68KCLK(CLK_68KCLK),
		.nRESET(nRESET),
		.dma_start(dma_start),
		.dma_mode(dma_mode),
		.dma_cfg(dma_cfg),
		.nbg(nbg),
		.nas(cpu.nas),
		.ndtack(cpu.ndtack),
		.dma_data_in(dma_data_in),
		.dma_sdram_busy(dma_sdram_busy),
		.nbr(nbr),
		.nbgack(nbgack),
		.dma_running(dma_running),
		.dma_mem(dma_mem)
	);

endmodule

// File: cd_dma.sv
// CD DMA engine, word copy and word fill
`timescale 1ns/100ps

module cd_dma(
	input logic CLK_68KCLK,
	input logic nRESET,
	input logic dma_start,
	input cd_dma_pkg::dma_mode_t dma_mode,
	input cd_dma_pkg::dma_cfg_t dma_cfg,
	input logic nbg,
	input logic nas,
	input logic ndtack,
	input cd_bus_pkg::word_t dma_data_in,
	input logic dma_sdram_busy,
	output logic nbr,
	output logic nbgack,
	output logic dma_running,
	output cd_dma_pkg::dma_mem_t dma_mem
);
	import cd_dma_pkg::*;

	dma_state_t state;
	dma_mode_t mode_run;		// Mode of the job in flight
	dma_count_t count_run;		// Words left
	logic [7:0] timer;			// Minimum rd/wr hold

	always_ff @(posedge CLK_68KCLK or negedge nRESET)
	begin
		if (!nRESET)
		begin
			state <= ST_IDLE;
			nbr <= 1'b1;
			nbgack <= 1'b1;
			dma_running <= 1'b0;
			timer <= 8'd0;
			dma_mem.rd <= 1'b0;
			dma_mem.wr <= 1'b0;
		end
		else
		begin
			// Timer keeps running during stalls
			if (timer != 8'd0)
				timer <= timer - 1'b1;

			if (dma_start && (state == ST_IDLE))
			begin
				state <= ST_REQ;
				dma_running <= 1'b1;
				mode_run <= dma_mode;
				count_run <= dma_cfg.count;
				if (dma_mode == MODE_WORD_FILL)
				begin
					dma_mem.addr_out <= dma_cfg.addr_a;
					dma_mem.data_out <= dma_cfg.value;	// Same word every time
				end
				else
				begin
					dma_mem.addr_in <= dma_cfg.addr_a;
					dma_mem.addr_out <= dma_cfg.addr_b;
				end
			end
			else if (!dma_sdram_busy && (timer == 8'd0))
			begin
				case (state)
					// ==========================================================
					// Bus arbitration
					// ==========================================================
					ST_REQ:
					begin
						nbr <= 1'b0;
						state <= ST_WAIT_GRANT;
					end
					ST_WAIT_GRANT:
						if (!nbg)
							state <= ST_WAIT_BUS_FREE;
					ST_WAIT_BUS_FREE:
					begin
						// Let the running CPU cycle finish
						if (nas && ndtack)
						begin
							nbr <= 1'b1;
							nbgack <= 1'b0;		// Bus is ours
							state <= ST_LOOP;
						end
					end

					// ==========================================================
					// Transfer loop
					// ==========================================================
					ST_LOOP:
					begin
						if (count_run == '0)
						begin
							state <= ST_IDLE;
							nbgack <= 1'b1;		// Hand the bus back
							dma_running <= 1'b0;
						end
						else if (mode_run == MODE_WORD_FILL)
						begin
							dma_mem.wr <= 1'b1;
							timer <= T_FILL;
							state <= ST_WRITE_DONE;
						end
						else
						begin
							dma_mem.rd <= 1'b1;	// Fetch source word
							timer <= T_READ;
							state <= ST_READ_DONE;
						end
					end
					ST_READ_DONE:
					begin
						dma_mem.rd <= 1'b0;
						dma_mem.wr <= 1'b1;
						dma_mem.data_out <= dma_data_in;
						dma_mem.addr_in <= dma_mem.addr_in + 24'd2;
						timer <= T_WRITE;
						state <= ST_WRITE_DONE;
					end
					ST_WRITE_DONE:
					begin
						dma_mem.wr <= 1'b0;
						dma_mem.addr_out <= dma_mem.addr_out + 24'd2;
						count_run <= count_run - 1'b1;
						state <= ST_LOOP;
					end
					default: state <= ST_IDLE;
				endcase
			end
		end
	end

	a_rd_wr_excl: assert property (@(posedge CLK_68KCLK) disable iff (!nRESET)
		!(dma_mem.rd && dma_mem.wr));

	// Writes only with the bus granted
	a_wr_owned: assert property (@(posedge CLK_68KCLK) disable iff (!nRESET)
		dma_mem.wr |-> !nbgack);

endmodule

// File: cd_irq.sv
// CD interrupt flags and vector
`timescale 1ns/100ps

module cd_irq(
	input logic CLK_68KCLK,
	input logic nRESET,
	input logic cdd_nirq,
	input logic cdc_nirq,
	input cd_bus_pkg::irq_ctl_t irq_ctl,
	output logic cd_irq,
	output logic [7:0] irq_vector
);
	import cd_bus_pkg::*;

	logic [1:0] cdd_sr, cdc_sr;	// [1] is the older sample
	logic [2:1] flags;			// Active low, 1 comm, 2 CDC
	logic cdd_fall, cdc_fall;

	assign cdd_fall = (cdd_sr == 2'b10);
	assign cdc_fall = (cdc_sr == 2'b10);

	always_ff @(posedge CLK_68KCLK or negedge nRESET)
	begin
		if (!nRESET)
		begin
			cdd_sr <= 2'b11;
			cdc_sr <= 2'b11;
			flags <= 2'b11;
			cd_irq <= 1'b1;
		end
		else
		begin
			cdd_sr <= {cdd_sr[0], cdd_nirq};
			cdc_sr <= {cdc_sr[0], cdc_nirq};

			if (irq_ctl.ack_valid)
				flags <= flags | irq_ctl.ack;	// Writing 1 clears the request

			// New edges win over a same-cycle ack
			if (cdd_fall & irq_ctl.comm_en)
				flags[1] <= 1'b0;
			if (cdc_fall)
				flags[2] <= 1'b0;	// Decoder or transfer end

			cd_irq <= &flags;
		end
	end

	// Comm first
	always_comb
	begin
		if (!flags[1])
			irq_vector = VEC_COMM;
		else if (!flags[2])
			irq_vector = VEC_CDC;
		else
			irq_vector = VEC_SPURIOUS;	// Should not be acked
	end

	// Line down means a real vector, except the cycle after an ack
	a_irq_src: assert property (@(posedge CLK_68KCLK) disable iff (!nRESET)
		(!cd_irq && !$past(irq_ctl.ack_valid)) |-> (irq_vector != VEC_SPURIOUS));

endmodule

// File: cd_regs.sv
// CD control registers
// Register decode, upload gating and read mux
`timescale 1ns/100ps

module cd_regs(
	input logic CLK_68KCLK,
	input logic nRESET,
	input cd_bus_pkg::cpu_bus_t cpu,
	input logic [1:0] system_type,
	input logic [1:0] cd_region,
	input logic cd_lid,
	input logic [7:0] irq_vector,
	input logic dma_running,
	input cd_dma_pkg::dma_mem_t dma_mem,
	output cd_bus_pkg::cd_ctrl_t ctrl,
	output cd_bus_pkg::tr_wr_t tr,
	output cd_dma_pkg::dma_cfg_t dma_cfg,
	output cd_dma_pkg::dma_mode_t dma_mode,
	output logic dma_start,
	output cd_bus_pkg::irq_ctl_t irq_ctl,
	output cd_bus_pkg::word_t rd_data,
	output logic rd_en
);
	import cd_bus_pkg::*;
	import cd_dma_pkg::*;

	logic nlds_prev, nuds_prev;
	logic strobe_fall;			// Either data strobe just went low
	logic reg_wr, zone_wr;
	logic [11:1] woff;			// Word offset in the FF0xxx window
	logic map_spr, map_pcm, map_z80, map_fix;
	logic upload_en;
	tr_area_t tr_area;
	word_t ucode0;
	word_t tr_data;
	logic [19:1] tr_addr;
	logic tr_zone;
	logic iack_rd, topmech_rd;

	assign strobe_fall = (nlds_prev & ~cpu.nlds) | (nuds_prev & ~cpu.nuds);
	assign woff = cpu.addr[11:1];
	// Register writes all use the low lane
	assign reg_wr = system_type[1] & strobe_fall & ~cpu.rw & ~cpu.nlds &
		(cpu.addr[23:12] == CD_WINDOW_HI);
	assign zone_wr = system_type[1] & strobe_fall & ~cpu.rw & (cpu.addr[23:20] == UPLOAD_ZONE);

	// ======================================================================
	// Control registers
	// ======================================================================

	always_ff @(posedge CLK_68KCLK or negedge nRESET)
	begin
		if (!nRESET)
		begin
			nlds_prev <= 1'b1;
			nuds_prev <= 1'b1;
			ctrl.video_en <= 1'b1;
			ctrl.fix_en <= 1'b1;
			ctrl.spr_en <= 1'b1;
			ctrl.nreset_z80 <= 1'b0;	// Z80 starts held
			ctrl.spr_bank <= 2'd0;
			ctrl.pcm_bank <= 1'b0;
			{map_spr, map_pcm, map_z80, map_fix} <= 4'b0000;
			upload_en <= 1'b0;
			tr_area <= AREA_SPR;
			irq_ctl <= '0;
			dma_mode <= MODE_WORD_COPY;
			dma_start <= 1'b0;
		end
		else
		begin
			nlds_prev <= cpu.nlds;
			nuds_prev <= cpu.nuds;
			dma_start <= 1'b0;				// Pulses
			irq_ctl.ack_valid <= 1'b0;
			if (reg_wr)
			begin
				case (woff)
					REG_IRQ_MASK[11:1]: irq_ctl.comm_en <= cpu.data[6] | cpu.data[4];
					REG_IRQ_ACK[11:1]:
					begin
						irq_ctl.ack_valid <= 1'b1;
						irq_ctl.ack <= cpu.data[5:4];	// Flags 2..1
					end
					REG_DMA_CTRL[11:1]:
					begin
						// Start only for a known job, otherwise ignored
						if (cpu.data[6] & ~dma_running)
						begin
							if (ucode0 == UCODE_WORD_COPY)
							begin
								dma_mode <= MODE_WORD_COPY;
								dma_start <= 1'b1;
							end
							else if (ucode0 == UCODE_WORD_FILL)
							begin
								dma_mode <= MODE_WORD_FILL;
								dma_start <= 1'b1;
							end
						end
					end
					REG_TR_AREA[11:1]: tr_area <= cpu.data[2:0];
					REG_DISBLSPR[11:1]: ctrl.spr_en <= ~cpu.data[0];
					REG_DISBLFIX[11:1]: ctrl.fix_en <= ~cpu.data[0];
					REG_ENVIDEO[11:1]: ctrl.video_en <= cpu.data[0];
					REG_UPMAPSPR[11:1]: map_spr <= 1'b1;
					REG_UPMAPPCM[11:1]: map_pcm <= 1'b1;
					REG_UPMAPZ80[11:1]: map_z80 <= 1'b1;
					REG_UPMAPFIX[11:1]: map_fix <= 1'b1;
					REG_UPUNMAPSPR[11:1]: map_spr <= 1'b0;
					REG_UPUNMAPPCM[11:1]: map_pcm <= 1'b0;
					REG_UPUNMAPZ80[11:1]: map_z80 <= 1'b0;
					REG_UPUNMAPFIX[11:1]: map_fix <= 1'b0;
					REG_UPLOAD_EN[11:1]: upload_en <= cpu.data[0];
					REG_Z80_RESET[11:1]: ctrl.nreset_z80 <= cpu.data[0];
					REG_SPRBANK[11:1]: ctrl.spr_bank <= cpu.data[1:0];
					REG_PCMBANK[11:1]: ctrl.pcm_bank <= cpu.data[0];
					default: ;
				endcase
			end
		end
	end

	// DMA setup, microcode and upload latch
	always_ff @(posedge CLK_68KCLK)
	begin
		if (reg_wr)
		begin
			case (woff)
				REG_DMA_ADDR_A_HI[11:1]: dma_cfg.addr_a[23:16] <= cpu.data[7:0];
				REG_DMA_ADDR_A_LO[11:1]: dma_cfg.addr_a[15:0] <= cpu.data;
				REG_DMA_ADDR_B_HI[11:1]: dma_cfg.addr_b[23:16] <= cpu.data[7:0];
				REG_DMA_ADDR_B_LO[11:1]: dma_cfg.addr_b[15:0] <= cpu.data;
				REG_DMA_VALUE_HI[11:1]: dma_cfg.value <= cpu.data;
				REG_DMA_COUNT_HI[11:1]: dma_cfg.count[31:16] <= cpu.data;
				REG_DMA_COUNT_LO[11:1]: dma_cfg.count[15:0] <= cpu.data;
				REG_DMA_UCODE0[11:1]: ucode0 <= cpu.data;
				default: ;
			endcase
		end
		if (zone_wr)
		begin
			tr_data <= cpu.data;
			tr_addr <= cpu.addr[19:1];
		end
	end

	// ======================================================================
	// Upload gating, DMA owns the zone while running
	// ======================================================================

	always_comb
	begin
		if (dma_running)
			tr_zone = upload_en & dma_mem.wr & (dma_mem.addr_out[23:20] == UPLOAD_ZONE);
		else
			tr_zone = upload_en & ~cpu.rw & (cpu.addr[23:20] == UPLOAD_ZONE);
		// Only mapped areas may be written
		tr.wr_spr = tr_zone & map_spr & (tr_area == AREA_SPR);
		tr.wr_pcm = tr_zone & map_pcm & (tr_area == AREA_PCM);
		tr.wr_z80 = tr_zone & map_z80 & (tr_area == AREA_Z80);
		tr.wr_fix = tr_zone & map_fix & (tr_area == AREA_FIX);
		tr.area = tr_area;
		tr.data = dma_running ? dma_mem.data_out : tr_data;
		tr.addr = dma_running ? dma_mem.addr_out[19:1] : tr_addr;
	end

	// Read mux
	assign iack_rd = ~cpu.nas & cpu.rw & cpu.iack & (cpu.addr[3:1] == 3'd4);
	assign topmech_rd = ~cpu.nas & cpu.rw & system_type[1] &
		(cpu.addr[23:12] == CD_WINDOW_HI) & (woff == REG_TOPMECH[11:1]);
	assign rd_en = iack_rd | topmech_rd;
	assign rd_data = iack_rd ? {8'h00, irq_vector} :
		topmech_rd ? {3'b110, cd_lid, 2'b11, cd_region, 8'h00} :	// Jumpers in [11:8]
		'0;

	// Target area steady under an upload strobe
	a_tr_area_stable: assert property (@(posedge CLK_68KCLK) disable iff (!nRESET)
		(|{tr.wr_spr, tr.wr_pcm, tr.wr_z80, tr.wr_fix}) |-> $stable(tr_area));

endmodule

// File: cd_dma_pkg.sv
// DMA engine types and constants
package cd_dma_pkg;

	typedef logic [23:0] dma_addr_t;	// Byte address
	typedef logic [31:0] dma_count_t;	// Words

	// ======================================================================
	// Modes and microcode signatures
	// ======================================================================

	typedef enum logic {
		MODE_WORD_COPY,
		MODE_WORD_FILL
	} dma_mode_t;

	// First microcode word identifies the job
	localparam logic [15:0] UCODE_WORD_COPY = 16'hFE6D;	// A -> B
	localparam logic [15:0] UCODE_WORD_FILL = 16'hFFCD;	// Value -> A

	// ======================================================================
	// Sequencer
	// ======================================================================

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_REQ,				// Drop nBR
		ST_WAIT_GRANT,		// Wait for nBG
		ST_WAIT_BUS_FREE,	// Wait for the current cycle to end
		ST_LOOP,			// One word per pass
		ST_READ_DONE,
		ST_WRITE_DONE
	} dma_state_t;

	// Minimum rd/wr hold times in clocks
	localparam logic [7:0] T_READ = 8'd20;
	localparam logic [7:0] T_WRITE = 8'd20;
	localparam logic [7:0] T_FILL = 8'd20;

	// Job setup written by the CPU
	typedef struct packed {
		dma_addr_t addr_a;
		dma_addr_t addr_b;
		cd_bus_pkg::word_t value;	// Fill word
		dma_count_t count;
	} dma_cfg_t;

	// Memory side of the engine
	typedef struct packed {
		logic rd;
		logic wr;
		dma_addr_t addr_in;			// Read pointer
		dma_addr_t addr_out;		// Write pointer
		cd_bus_pkg::word_t data_out;
	} dma_mem_t;

endpackage

// File: cd_bus_pkg.sv
// 68k bus, register map and control output types
package cd_bus_pkg;

	// ======================================================================
	// Bus types
	// ======================================================================

	typedef logic [15:0] word_t;
	typedef logic [23:1] cpu_addr_t;	// Word address, no A0 on the 68k
	typedef logic [2:0] tr_area_t;		// Upload target select

	// 68k bus as seen from the CD block
	typedef struct packed {
		cpu_addr_t addr;
		word_t data;		// CPU write data
		logic rw;			// High for read
		logic nas;
		logic nlds;
		logic nuds;
		logic iack;			// Interrupt acknowledge cycle
		logic ndtack;
	} cpu_bus_t;

	// Upload areas
	localparam tr_area_t AREA_SPR = 3'd0;
	localparam tr_area_t AREA_PCM = 3'd1;
	localparam tr_area_t AREA_Z80 = 3'd4;
	localparam tr_area_t AREA_FIX = 3'd5;

	// Video and bank controls
	typedef struct packed {
		logic video_en;
		logic fix_en;
		logic spr_en;
		logic nreset_z80;	// Z80 held in reset while low
		logic [1:0] spr_bank;
		logic pcm_bank;
	} cd_ctrl_t;

	// Upload zone write port
	typedef struct packed {
		logic wr_spr;
		logic wr_pcm;
		logic wr_z80;
		logic wr_fix;
		tr_area_t area;
		word_t data;
		logic [19:1] addr;	// Offset inside the E zone
	} tr_wr_t;

	// ======================================================================
	// Register map, byte offsets inside FF0xxx
	// ======================================================================

	localparam logic [11:0] REG_IRQ_MASK = 12'h002;
	localparam logic [11:0] REG_IRQ_ACK = 12'h00E;
	localparam logic [11:0] REG_DMA_CTRL = 12'h061;			// Bit 6 starts DMA
	localparam logic [11:0] REG_DMA_ADDR_A_HI = 12'h064;
	localparam logic [11:0] REG_DMA_ADDR_A_LO = 12'h066;
	localparam logic [11:0] REG_DMA_ADDR_B_HI = 12'h068;
	localparam logic [11:0] REG_DMA_ADDR_B_LO = 12'h06A;
	localparam logic [11:0] REG_DMA_VALUE_HI = 12'h06C;
	localparam logic [11:0] REG_DMA_COUNT_HI = 12'h070;
	localparam logic [11:0] REG_DMA_COUNT_LO = 12'h072;
	localparam logic [11:0] REG_DMA_UCODE0 = 12'h07E;		// First microcode word
	localparam logic [11:0] REG_TR_AREA = 12'h105;
	localparam logic [11:0] REG_DISBLSPR = 12'h111;
	localparam logic [11:0] REG_DISBLFIX = 12'h115;
	localparam logic [11:0] REG_ENVIDEO = 12'h119;
	localparam logic [11:0] REG_UPMAPSPR = 12'h121;
	localparam logic [11:0] REG_UPMAPPCM = 12'h123;
	localparam logic [11:0] REG_UPMAPZ80 = 12'h127;
	localparam logic [11:0] REG_UPMAPFIX = 12'h129;
	localparam logic [11:0] REG_UPUNMAPSPR = 12'h141;
	localparam logic [11:0] REG_UPUNMAPPCM = 12'h143;
	localparam logic [11:0] REG_UPUNMAPZ80 = 12'h147;
	localparam logic [11:0] REG_UPUNMAPFIX = 12'h149;
	localparam logic [11:0] REG_UPLOAD_EN = 12'h16F;
	localparam logic [11:0] REG_Z80_RESET = 12'h183;
	localparam logic [11:0] REG_SPRBANK = 12'h1A1;
	localparam logic [11:0] REG_PCMBANK = 12'h1A3;
	localparam logic [11:0] REG_TOPMECH = 12'h11C;		// Read only

	localparam logic [11:0] CD_WINDOW_HI = 12'hFF0;	// A23..A12
	localparam logic [3:0] UPLOAD_ZONE = 4'hE;		// A23..A20

	// Autovectors
	localparam logic [7:0] VEC_COMM = 8'd22;
	localparam logic [7:0] VEC_CDC = 8'd21;
	localparam logic [7:0] VEC_SPURIOUS = 8'd24;

	// Interrupt controls from the register block
	typedef struct packed {
		logic comm_en;
		logic ack_valid;	// One cycle pulse
		logic [1:0] ack;	// Flags 2..1
	} irq_ctl_t;

endpackage
